// File: logic/bus_pkg.sv
package bus_pkg;

    // ==============================
    // widths
    // ==============================

    localparam int ADDR_WIDTH = 32;
    localparam int WORD_WIDTH = 32;
    localparam int MASK_WIDTH = WORD_WIDTH / 8; // one enable per byte lane

    typedef logic [ADDR_WIDTH-1:0]              addr_t;
    typedef logic [WORD_WIDTH-1:0]              word_t;
    typedef logic [MASK_WIDTH-1:0]              mask_t;
    typedef logic [map_pkg::DEV_ADDR_WIDTH-1:0] dev_addr_t; // word offset inside a device

    // ==============================
    // request and response
    // ==============================

    typedef struct packed {
        logic  read;
        logic  write;
        addr_t address;
        word_t data_wr;
        mask_t mask;
    } cpu_req_t;

    typedef struct packed {
        word_t data_rd;
        logic  stall;
        logic  interrupt;
    } cpu_rsp_t;

    typedef struct packed {
        logic      read;
        logic      write;
        dev_addr_t address;
        word_t     data_wr;
        mask_t     mask;
    } dev_req_t;

    typedef struct packed {
        word_t data_rd;
        logic  stall;
        logic  interrupt;
    } dev_rsp_t;

endpackage

// File: logic/byte_fifo.sv
`timescale 1ns/1ns

module byte_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         push,
    input  logic [7:0]                   push_data,
    output logic                         full,
    input  logic                         pop,
    output logic [7:0]                   pop_data,
    output logic                         empty,
    output logic [$clog2(DEPTH + 1)-1:0] count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [7:0]       mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1; // wraps for any depth
    endfunction

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr]; // head is visible before the pop

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

endmodule

// File: logic/data_bus.sv
`timescale 1ns/1ns

module data_bus (
    input  bus_pkg::cpu_req_t cpu,
    output bus_pkg::cpu_rsp_t cpu_rsp,
    output bus_pkg::dev_req_t ram_req,
    output bus_pkg::dev_req_t uart_req,
    output bus_pkg::dev_req_t timer_req,
    input  bus_pkg::dev_rsp_t ram_rsp,
    input  bus_pkg::dev_rsp_t uart_rsp,
    input  bus_pkg::dev_rsp_t timer_rsp
);

    map_pkg::region_t region;

    assign region = cpu.address[bus_pkg::ADDR_WIDTH - 1 -: map_pkg::REGION_WIDTH];

    always_comb begin
        // payload fans out to every device, only the strobes are steered
        ram_req         = '0;
        ram_req.address = bus_pkg::dev_addr_t'(cpu.address[2 +: map_pkg::RAM_ADDR_WIDTH]);
        ram_req.data_wr = cpu.data_wr;
        ram_req.mask    = cpu.mask;

        uart_req         = '0;
        uart_req.address = bus_pkg::dev_addr_t'(cpu.address[2 +: map_pkg::UART_ADDR_WIDTH]);
        uart_req.data_wr = cpu.data_wr;
        uart_req.mask    = cpu.mask;

        timer_req         = '0;
        timer_req.address = bus_pkg::dev_addr_t'(cpu.address[2 +: map_pkg::TIMER_ADDR_WIDTH]);
        timer_req.data_wr = cpu.data_wr;
        timer_req.mask    = cpu.mask;

        cpu_rsp.data_rd   = '0;
        cpu_rsp.stall     = 1'b0;
        cpu_rsp.interrupt = uart_rsp.interrupt; // only the uart can interrupt

        unique case (region)
            map_pkg::REGION_RAM: begin
                ram_req.read    = cpu.read;
                ram_req.write   = cpu.write;
                cpu_rsp.data_rd = ram_rsp.data_rd;
                cpu_rsp.stall   = ram_rsp.stall;
            end

            map_pkg::REGION_UART: begin
                uart_req.read   = cpu.read;
                uart_req.write  = cpu.write;
                cpu_rsp.data_rd = uart_rsp.data_rd;
                cpu_rsp.stall   = uart_rsp.stall; // full fifo holds the cpu
            end

            map_pkg::REGION_TIMER: begin
                timer_req.read  = cpu.read;
                timer_req.write = cpu.write;
                cpu_rsp.data_rd = timer_rsp.data_rd;
                cpu_rsp.stall   = timer_rsp.stall;
            end

            default: begin
                cpu_rsp.data_rd = '0; // unmapped space reads as zero
            end
        endcase
    end

endmodule

// File: logic/interval_timer.sv
`timescale 1ns/1ns

module interval_timer (
    input  logic              clk,
    input  logic              arst_n,
    input  bus_pkg::dev_req_t req,
    output bus_pkg::dev_rsp_t rsp
);

    typedef logic [map_pkg::TIMER_ADDR_WIDTH-1:0] reg_sel_t;

    bus_pkg::word_t count;
    reg_sel_t       reg_sel;
    logic           expired;
    logic           load;
    logic           clear;
    logic           hit_zero;

    assign reg_sel  = req.address[map_pkg::TIMER_ADDR_WIDTH-1:0];
    assign load     = req.write && (reg_sel == reg_sel_t'(map_pkg::TIMER_REG_COUNT));
    assign clear    = req.write && (reg_sel == reg_sel_t'(map_pkg::TIMER_REG_EXPIRED));
    assign hit_zero = !load && (count == bus_pkg::word_t'(1)); // last decrement

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count   <= '0;
            expired <= 1'b0;
        end else begin
            if (load) count <= req.data_wr;
            else if (count != '0) count <= count - 1'b1;

            // a new expiry wins over a clear in the same cycle
            if (hit_zero) expired <= 1'b1;
            else if (clear) expired <= 1'b0;
        end
    end

    always_comb begin
        rsp.stall     = 1'b0;
        rsp.interrupt = 1'b0; // expiry is polled
        case (reg_sel)
            reg_sel_t'(map_pkg::TIMER_REG_COUNT): rsp.data_rd = count;
            default:                              rsp.data_rd = {31'b0, expired};
        endcase
    end

endmodule

// File: logic/map_pkg.sv
package map_pkg;

    // ==============================
    // region decode
    // ==============================

    localparam int REGION_WIDTH = 4;

    typedef logic [REGION_WIDTH-1:0] region_t; // top bits of the byte address

    localparam region_t REGION_RAM   = region_t'(0);
    localparam region_t REGION_UART  = region_t'(1);
    localparam region_t REGION_TIMER = region_t'(2);

    // ==============================
    // device word offsets
    // ==============================

    localparam int RAM_ADDR_WIDTH   = 10; // 1024 words of sram
    localparam int UART_ADDR_WIDTH  = 2;
    localparam int TIMER_ADDR_WIDTH = 1;

    localparam int DEV_ADDR_WIDTH =
        (RAM_ADDR_WIDTH >= UART_ADDR_WIDTH && RAM_ADDR_WIDTH >= TIMER_ADDR_WIDTH) ?
            RAM_ADDR_WIDTH :
        (UART_ADDR_WIDTH >= TIMER_ADDR_WIDTH) ?
            UART_ADDR_WIDTH :
            TIMER_ADDR_WIDTH; // every device port carries the widest offset

    // uart register offsets
    localparam int UART_REG_DATA   = 0;
    localparam int UART_REG_STATUS = 1;
    localparam int UART_REG_CTRL   = 2;

    // timer register offsets
    localparam int TIMER_REG_COUNT   = 0;
    localparam int TIMER_REG_EXPIRED = 1;

endpackage

// File: logic/soc_data_path.sv
`timescale 1ns/1ns

module soc_data_path #(
    parameter int RAM_WAIT_STATES   = 2,
    parameter int UART_CLKS_PER_BIT = 8,
    parameter int UART_FIFO_DEPTH   = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  bus_pkg::cpu_req_t cpu_req,
    output bus_pkg::cpu_rsp_t cpu_rsp,
    output logic              uart_tx_line
);

    bus_pkg::dev_req_t ram_req;
    bus_pkg::dev_req_t uart_req;
    bus_pkg::dev_req_t timer_req;
    bus_pkg::dev_rsp_t ram_rsp;
    bus_pkg::dev_rsp_t uart_rsp;
    bus_pkg::dev_rsp_t timer_rsp;

    // ==============================
    // decoder and devices
    // ==============================

    data_bus i_data_bus (
        .cpu(cpu_req), .cpu_rsp(cpu_rsp),
        .ram_req(ram_req), .uart_req(uart_req), .timer_req(timer_req),
        .ram_rsp(ram_rsp), .uart_rsp(uart_rsp), .timer_rsp(timer_rsp)
    );

    sram_port #(
        .WORDS(2 ** map_pkg::RAM_ADDR_WIDTH), .WAIT_STATES(RAM_WAIT_STATES)
    ) i_sram_port (.clk(clk), .arst_n(arst_n), .req(ram_req), .rsp(ram_rsp));

    uart_tx #(
        .CLKS_PER_BIT(UART_CLKS_PER_BIT), .FIFO_DEPTH(UART_FIFO_DEPTH)
    ) i_uart_tx (.clk(clk), .arst_n(arst_n), .req(uart_req), .rsp(uart_rsp), .tx(uart_tx_line));

    interval_timer i_interval_timer (.clk(clk), .arst_n(arst_n), .req(timer_req), .rsp(timer_rsp));

endmodule

// File: logic/sram_port.sv
`timescale 1ns/1ns

module sram_port #(
    parameter int WORDS       = 1024,
    parameter int WAIT_STATES = 2
) (
    input  logic              clk,
    input  logic              arst_n,
    input  bus_pkg::dev_req_t req,
    output bus_pkg::dev_rsp_t rsp
);

    localparam int IDX_W  = (WORDS > 1) ? $clog2(WORDS) : 1;
    localparam int WAIT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    bus_pkg::word_t mem [WORDS];

    logic [IDX_W-1:0]  idx;
    logic [WAIT_W-1:0] wait_cnt;
    logic              active;
    logic              stall;

    assign idx    = req.address[IDX_W-1:0];
    assign active = req.read || req.write;
    assign stall  = active && (wait_cnt != WAIT_W'(WAIT_STATES)); // low once the waits are spent

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
        end else if (stall) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0; // clears on completion and while idle
        end
    end

    always_ff @(posedge clk) begin
        if (req.write && !stall) begin
            for (int i = 0; i < bus_pkg::MASK_WIDTH; i++) begin
                if (req.mask[i]) begin
                    mem[idx][8*i +: 8] <= req.data_wr[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        rsp.data_rd   = mem[idx];
        rsp.stall     = stall;
        rsp.interrupt = 1'b0;
    end

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/1ns

module uart_tx #(
    parameter int CLKS_PER_BIT = 8,
    parameter int FIFO_DEPTH   = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  bus_pkg::dev_req_t req,
    output bus_pkg::dev_rsp_t rsp,
    output logic              tx
);

    localparam int CLK_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [map_pkg::UART_ADDR_WIDTH-1:0] reg_sel_t;
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t        tx_state;
    reg_sel_t         reg_sel;
    logic [CLK_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;
    logic [7:0]       fifo_data;
    logic [CNT_W-1:0] fifo_count;
    logic             fifo_push;
    logic             fifo_pop;
    logic             fifo_full;
    logic             fifo_empty;
    logic             bit_end;
    logic             busy;
    logic             irq_en;

    assign reg_sel   = req.address[map_pkg::UART_ADDR_WIDTH-1:0];
    assign fifo_push = req.write && (reg_sel == reg_sel_t'(map_pkg::UART_REG_DATA)) && !fifo_full;
    assign fifo_pop  = (tx_state == TX_IDLE) && !fifo_empty;
    assign bit_end   = (clk_cnt == CLK_W'(CLKS_PER_BIT - 1));
    assign busy      = (tx_state != TX_IDLE);

    byte_fifo #(.DEPTH(FIFO_DEPTH)) i_byte_fifo (
        .clk(clk), .arst_n(arst_n), .push(fifo_push), .push_data(req.data_wr[7:0]),
        .full(fifo_full), .pop(fifo_pop), .pop_data(fifo_data), .empty(fifo_empty),
        .count(fifo_count)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) irq_en <= 1'b0;
        else if (req.write && reg_sel == reg_sel_t'(map_pkg::UART_REG_CTRL)) irq_en <= req.data_wr[0];
    end

    always_comb begin
        rsp.stall     = req.write && (reg_sel == reg_sel_t'(map_pkg::UART_REG_DATA)) && fifo_full;
        rsp.interrupt = irq_en && fifo_empty && !busy; // whole queue has drained
        case (reg_sel)
            reg_sel_t'(map_pkg::UART_REG_STATUS): rsp.data_rd = {16'b0, 8'(fifo_count), 6'b0, busy, fifo_empty};
            reg_sel_t'(map_pkg::UART_REG_CTRL):   rsp.data_rd = {31'b0, irq_en};
            default:                              rsp.data_rd = '0;
        endcase
    end

    // ==============================
    // 8N1 transmitter
    // ==============================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_state <= TX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
        end else begin
            clk_cnt <= (tx_state == TX_IDLE || bit_end) ? '0 : clk_cnt + 1'b1;
            case (tx_state)
                TX_IDLE:  if (fifo_pop) tx_state <= TX_START;
                TX_START: if (bit_end) tx_state <= TX_DATA;
                TX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1; // wraps back to 0 after bit 7
                        if (bit_idx == 3'd7) tx_state <= TX_STOP;
                    end
                end
                default:  if (bit_end) tx_state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop) shift_q <= fifo_data;
        else if (tx_state == TX_DATA && bit_end) shift_q <= shift_q >> 1; // lsb goes first
    end

    always_comb begin
        case (tx_state)
            TX_START: tx = 1'b0;
            TX_DATA:  tx = shift_q[0];
            default:  tx = 1'b1; // line idles high and stop bit is high
        endcase
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the soc_data_path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module soc_data_path_tb -f soc_data_path.f \
    --Mdir obj_dir -o soc_data_path_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/soc_data_path_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "PASS: all tests" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

// File: soc_data_path.f
logic/map_pkg.sv
logic/bus_pkg.sv
logic/data_bus.sv
logic/sram_port.sv
logic/byte_fifo.sv
logic/uart_tx.sv
logic/interval_timer.sv
logic/soc_data_path.sv
tests/soc_data_path_checker.sv
tests/soc_data_path_tb.sv

// File: tests/soc_data_path_checker.sv
`timescale 1ns/1ns

module soc_data_path_checker (
    input logic              clk,
    input logic              arst_n,
    input bus_pkg::cpu_req_t cpu_req,
    input bus_pkg::cpu_rsp_t cpu_rsp,
    input logic              uart_tx_line,
    input logic              tx_busy,
    input logic              irq_en
);

    logic strobe;

    assign strobe = cpu_req.read || cpu_req.write;

    stall_needs_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        cpu_rsp.stall |-> strobe)
        else $error("stall is high with no read or write strobe");

    request_held: assert property (@(posedge clk) disable iff (!arst_n)
        cpu_rsp.stall |=> $stable(cpu_req)) // requester waits out the stall
        else $error("request fields changed while stalled");

    line_idles_high: assert property (@(posedge clk) disable iff (!arst_n)
        !tx_busy |-> uart_tx_line)
        else $error("uart_tx_line is low while the transmitter is idle");

    irq_gated: assert property (@(posedge clk) disable iff (!arst_n)
        !irq_en |-> !cpu_rsp.interrupt)
        else $error("interrupt is high while the uart enable is clear");

endmodule

bind soc_data_path soc_data_path_checker i_soc_data_path_checker (
    .clk(clk), .arst_n(arst_n), .cpu_req(cpu_req), .cpu_rsp(cpu_rsp),
    .uart_tx_line(uart_tx_line), .tx_busy(i_uart_tx.busy), .irq_en(i_uart_tx.irq_en)
);

// File: tests/soc_data_path_tb.sv
`timescale 1ns/1ns

module soc_data_path_tb;

    localparam int RAM_WAIT_STATES   = 2;
    localparam int UART_CLKS_PER_BIT = 8;
    localparam int UART_FIFO_DEPTH   = 4;
    localparam int MAX_OPS           = 64;
    localparam int FRAME_CYCLES      = 10 * UART_CLKS_PER_BIT; // start, 8 data, stop
    localparam int CYCLES_PER_OP     = FRAME_CYCLES * UART_FIFO_DEPTH + 100;

    logic              clk;
    logic              arst_n;
    bus_pkg::cpu_req_t cpu_req;
    bus_pkg::cpu_rsp_t cpu_rsp;
    logic              uart_tx_line;

    logic [31:0] test_words [4*MAX_OPS]; // op, address, data, mask per line
    logic [7:0]  rx_bytes [$];
    int          num_ops;
    int          error_count;

    soc_data_path #(
        .RAM_WAIT_STATES(RAM_WAIT_STATES), .UART_CLKS_PER_BIT(UART_CLKS_PER_BIT),
        .UART_FIFO_DEPTH(UART_FIFO_DEPTH)
    ) i_soc_data_path (
        .clk(clk), .arst_n(arst_n), .cpu_req(cpu_req), .cpu_rsp(cpu_rsp),
        .uart_tx_line(uart_tx_line)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==============================
    // checks
    // ==============================

    task automatic abort_run();
        error_count++;
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input bus_pkg::word_t got,
                                input bus_pkg::word_t expected);
        if (got !== expected) begin
            $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, expected);
            abort_run();
        end
    endtask

    task automatic compare_byte(input string name, input logic [7:0] got,
                                input logic [7:0] expected);
        if (got !== expected) begin
            $display("mismatch %s: got 0x%02h, expected 0x%02h", name, got, expected);
            abort_run();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("mismatch %s: got 0x%01h, expected 0x%01h", name, got, expected);
            abort_run();
        end
    endtask

    // ram always waits, a full uart fifo may hold a data write, the rest never stall
    task automatic check_stalls(input bus_pkg::addr_t addr, input logic is_write,
                                input int stalls);
        map_pkg::region_t region;
        logic             uart_data_write;
        region          = addr[31:28];
        uart_data_write = is_write && region == map_pkg::REGION_UART &&
                          addr[3:2] == 2'(map_pkg::UART_REG_DATA);
        if (region == map_pkg::REGION_RAM) begin
            compare_word("ram stall cycles", bus_pkg::word_t'(stalls),
                         bus_pkg::word_t'(RAM_WAIT_STATES));
        end else if (!uart_data_write) begin
            compare_word("stall cycles", bus_pkg::word_t'(stalls), '0);
        end
    endtask

    // ==============================
    // cpu model
    // ==============================

    task automatic cpu_access(input logic is_write, input bus_pkg::addr_t addr,
                              input bus_pkg::word_t wdata, input bus_pkg::mask_t mask,
                              output bus_pkg::word_t rdata, output int stalls);
        @(posedge clk);
        #1;
        cpu_req.read    = !is_write;
        cpu_req.write   = is_write;
        cpu_req.address = addr;
        cpu_req.data_wr = wdata;
        cpu_req.mask    = mask;
        stalls          = 0;
        @(negedge clk);
        while (cpu_rsp.stall) begin
            stalls++; // this edge does not complete the transfer
            @(negedge clk);
        end
        rdata = cpu_rsp.data_rd;
        @(posedge clk);
        #1;
        cpu_req = '0;
    endtask

    initial begin : cpu_main
        bus_pkg::word_t rdata;
        bus_pkg::addr_t addr;
        bus_pkg::word_t data;
        bus_pkg::mask_t mask;
        logic [7:0]     rx_byte;
        logic [31:0]    op;
        int             stalls;
        int             n;
        cpu_req     = '0;
        arst_n      = 1'b0;
        error_count = 0;
        n           = 0;
        for (int i = 0; i < 4*MAX_OPS; i++) begin
            test_words[i] = '0;
        end
        $readmemh("tests/soc_data_path_tests.txt", test_words);
        while (n < MAX_OPS && test_words[4*n] != 0) n++;
        if (n == 0) begin
            $display("the tests file holds no operations");
            abort_run();
        end
        num_ops = n; // starts the watchdog
        repeat (10) @(posedge clk);
        #1 arst_n = 1'b1;

        for (int i = 0; i < num_ops; i++) begin
            op   = test_words[4*i];
            addr = test_words[4*i+1];
            data = test_words[4*i+2];
            mask = test_words[4*i+3][3:0];
            case (op)
                1: begin
                    cpu_access(1'b1, addr, data, mask, rdata, stalls);
                    check_stalls(addr, 1'b1, stalls);
                end
                2: begin
                    cpu_access(1'b0, addr, '0, '0, rdata, stalls);
                    check_stalls(addr, 1'b0, stalls);
                    compare_word($sformatf("data_rd at 0x%08h", addr), rdata, data);
                end
                3: repeat (data) @(posedge clk);
                4: begin
                    while (rx_bytes.size() == 0) @(posedge clk);
                    rx_byte = rx_bytes.pop_front();
                    compare_byte("uart_tx_line byte", rx_byte, data[7:0]);
                end
                5: begin
                    @(negedge clk);
                    compare_bit("interrupt", cpu_rsp.interrupt, data[0]);
                end
                default: begin
                    $display("unknown operation code %0d on test line %0d", op, i);
                    abort_run();
                end
            endcase
        end

        if (error_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run();
        end
    end

    // ==============================
    // serial receiver and watchdog
    // ==============================

    initial begin : serial_receiver
        logic [7:0] rx_byte;
        @(posedge arst_n);
        forever begin
            @(negedge uart_tx_line);
            repeat (UART_CLKS_PER_BIT / 2) @(negedge clk); // move to the bit centre
            if (uart_tx_line !== 1'b0) begin
                $display("serial start bit did not stay low until its centre");
                abort_run();
            end
            for (int i = 0; i < 8; i++) begin
                repeat (UART_CLKS_PER_BIT) @(negedge clk);
                rx_byte[i] = uart_tx_line;
            end
            repeat (UART_CLKS_PER_BIT) @(negedge clk);
            if (uart_tx_line !== 1'b1) begin
                $display("serial stop bit was low, the frame is broken");
                abort_run();
            end
            rx_bytes.push_back(rx_byte);
        end
    end

    initial begin : watchdog
        wait (num_ops > 0);
        repeat (num_ops * CYCLES_PER_OP + 20) @(posedge clk);
        $display("timeout: the %0d test operations did not finish in time", num_ops);
        abort_run();
    end

endmodule

// File: tests/soc_data_path_tests.txt
// columns: op address data mask, all hex
// op 1 write, 2 read (data is expected), 3 wait data cycles, 4 expect uart byte, 5 expect irq
1 00000010 11223344 f
2 00000010 11223344 0
1 00000010 aabbccdd 5
2 00000010 11bb33dd 0
1 00000ffc 01020304 f
1 00000ffc ffffffff 8
2 00000ffc ff020304 0
2 00000010 11bb33dd 0
// uart: interrupt enable, then a burst longer than the fifo
1 10000008 00000001 f
2 10000008 00000001 0
5 00000000 00000001 0
1 10000000 00000055 1
1 10000000 000000a3 1
1 10000000 0000000f 1
1 10000000 000000f0 1
1 10000000 00000081 1
1 10000000 0000007e 1
5 00000000 00000000 0
4 00000000 00000055 0
4 00000000 000000a3 0
4 00000000 0000000f 0
4 00000000 000000f0 0
4 00000000 00000081 0
4 00000000 0000007e 0
3 00000000 00000010 0
2 10000004 00000001 0
5 00000000 00000001 0
1 10000008 00000000 f
5 00000000 00000000 0
// timer load, expiry, clear
1 20000000 00000014 f
2 20000004 00000000 0
3 00000000 00000020 0
2 20000004 00000001 0
2 20000000 00000000 0
1 20000004 00000000 f
2 20000004 00000000 0
// unmapped regions
2 30000000 00000000 0
2 f0000010 00000000 0
